//--- rs5_isa_pkg.sv
// RV32I subset ISA package with widths, the operation enumeration and the major opcodes
package rs5_isa_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int TAG_W      = 3;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [TAG_W-1:0]      tag_t;

    //////////////////////////////
    // Operations
    //////////////////////////////
    // ADDI decodes as ADD with the I immediate as second operand
    typedef enum logic [3:0] {
        NOP     = 4'd0,
        ADD     = 4'd1,
        SUB     = 4'd2,
        AND     = 4'd3,
        OR      = 4'd4,
        XOR     = 4'd5,
        LUI     = 4'd6,
        LW      = 4'd7,
        SW      = 4'd8,
        BEQ     = 4'd9,
        BNE     = 4'd10,
        JAL     = 4'd11,
        INVALID = 4'd15
    } op_e;

    // Major opcodes, bits 6:0 of the instruction
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

endpackage

//--- rs5_pipe_pkg.sv
// Pipeline package with the stage register structs and the data memory request
package rs5_pipe_pkg;

    // Decode to execute
    typedef struct packed {
        logic                   valid;
        rs5_isa_pkg::op_e       op;
        rs5_isa_pkg::reg_addr_t rd;
        rs5_isa_pkg::word_t     first_op;
        rs5_isa_pkg::word_t     second_op;
        // Store data or jump offset
        rs5_isa_pkg::word_t     third_op;
        rs5_isa_pkg::word_t     pc;
        rs5_isa_pkg::tag_t      tag;
        logic                   we;
    } dec_exe_t;

    // Execute to retire
    typedef struct packed {
        logic                   valid;
        rs5_isa_pkg::op_e       op;
        rs5_isa_pkg::reg_addr_t rd;
        rs5_isa_pkg::word_t     result;
        rs5_isa_pkg::word_t     target;
        rs5_isa_pkg::word_t     store_data;
        rs5_isa_pkg::tag_t      tag;
        logic                   we;
        logic                   jump;
    } exe_ret_t;

    // Data memory request, full words only
    typedef struct packed {
        logic               en;
        logic               write;
        rs5_isa_pkg::word_t addr;
        rs5_isa_pkg::word_t wdata;
    } dmem_req_t;

endpackage

//--- rs5_fetch.sv
// Fetch stage holding the program counter and jump tag, redirected by retire
`timescale 1ns/1ps

module rs5_fetch #(
    parameter rs5_isa_pkg::word_t RESET_ADDR = '0
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               stall_i,
    input  logic               hazard_i,
    input  logic               jump_i,
    input  rs5_isa_pkg::word_t jump_target_i,
    output rs5_isa_pkg::word_t instruction_address_o,
    output rs5_isa_pkg::word_t pc_o,
    output rs5_isa_pkg::tag_t  tag_o
);

    rs5_isa_pkg::word_t pc;
    rs5_isa_pkg::tag_t  tag;
    logic               hold;

    assign hold = stall_i | hazard_i;

    // On hold the memory is asked again for the word now in decode
    assign instruction_address_o = hold ? pc_o : pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= RESET_ADDR;
            tag   <= '0;
            pc_o  <= RESET_ADDR;
            // First word after reset is seen twice, this copy dies at retire
            tag_o <= '1;
        end else if (!stall_i && (jump_i || !hazard_i)) begin
            pc_o  <= pc;
            tag_o <= tag;
            if (jump_i) begin
                pc  <= jump_target_i;
                tag <= tag + 1'b1;
            end else begin
                pc  <= pc + 32'd4;
            end
        end
    end

endmodule

//--- rs5_decode.sv
// Decode stage with field decode, immediates, operand selection and the hazard interlock
`timescale 1ns/1ps

module rs5_decode (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall_i,
    input  logic                   jump_i,
    input  rs5_isa_pkg::word_t     instruction_i,
    input  rs5_isa_pkg::word_t     pc_i,
    input  rs5_isa_pkg::tag_t      tag_i,
    input  rs5_isa_pkg::word_t     rs1_data_i,
    input  rs5_isa_pkg::word_t     rs2_data_i,
    output rs5_isa_pkg::reg_addr_t rs1_o,
    output rs5_isa_pkg::reg_addr_t rs2_o,
    output rs5_pipe_pkg::dec_exe_t dec_exe_o,
    output logic                   hazard_o
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    rs5_isa_pkg::reg_addr_t rd;
    rs5_isa_pkg::word_t     imm_i, imm_s, imm_b, imm_u, imm_j;
    rs5_isa_pkg::op_e       op;
    rs5_isa_pkg::word_t     first_op, second_op, third_op;
    logic                   use_rs1, use_rs2, we;

    assign opcode = instruction_i[6:0];
    assign rd     = instruction_i[11:7];
    assign funct3 = instruction_i[14:12];
    assign rs1_o  = instruction_i[19:15];
    assign rs2_o  = instruction_i[24:20];
    assign funct7 = instruction_i[31:25];

    //////////////////////////////
    // Immediates
    //////////////////////////////
    assign imm_i = {{20{instruction_i[31]}}, instruction_i[31:20]};
    assign imm_s = {{20{instruction_i[31]}}, instruction_i[31:25], instruction_i[11:7]};
    assign imm_b = {{19{instruction_i[31]}}, instruction_i[31], instruction_i[7],
                    instruction_i[30:25], instruction_i[11:8], 1'b0};
    assign imm_u = {instruction_i[31:12], 12'b0};
    assign imm_j = {{11{instruction_i[31]}}, instruction_i[31], instruction_i[19:12],
                    instruction_i[20], instruction_i[30:21], 1'b0};

    //////////////////////////////
    // Operation and operands
    //////////////////////////////
    always_comb begin
        op        = rs5_isa_pkg::INVALID;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        first_op  = rs1_data_i;
        second_op = rs2_data_i;
        third_op  = rs2_data_i;
        case (opcode)
            rs5_isa_pkg::OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: op = rs5_isa_pkg::ADD;
                    {7'h20, 3'b000}: op = rs5_isa_pkg::SUB;
                    {7'h00, 3'b111}: op = rs5_isa_pkg::AND;
                    {7'h00, 3'b110}: op = rs5_isa_pkg::OR;
                    {7'h00, 3'b100}: op = rs5_isa_pkg::XOR;
                    default:         op = rs5_isa_pkg::INVALID;
                endcase
            end
            rs5_isa_pkg::OPC_OP_IMM: begin
                op        = (funct3 == 3'b000) ? rs5_isa_pkg::ADD : rs5_isa_pkg::INVALID;
                use_rs1   = 1'b1;
                second_op = imm_i;
            end
            rs5_isa_pkg::OPC_LUI: begin
                op        = rs5_isa_pkg::LUI;
                second_op = imm_u;
            end
            rs5_isa_pkg::OPC_LOAD: begin
                op        = (funct3 == 3'b010) ? rs5_isa_pkg::LW : rs5_isa_pkg::INVALID;
                use_rs1   = 1'b1;
                second_op = imm_i;
            end
            rs5_isa_pkg::OPC_STORE: begin
                op        = (funct3 == 3'b010) ? rs5_isa_pkg::SW : rs5_isa_pkg::INVALID;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                second_op = imm_s;
            end
            rs5_isa_pkg::OPC_BRANCH: begin
                if (funct3 == 3'b000) begin
                    op = rs5_isa_pkg::BEQ;
                end else if (funct3 == 3'b001) begin
                    op = rs5_isa_pkg::BNE;
                end
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                third_op = imm_b;
            end
            rs5_isa_pkg::OPC_JAL: begin
                // Link value is pc + 4, the target uses the third operand
                op        = rs5_isa_pkg::JAL;
                first_op  = pc_i;
                second_op = 32'd4;
                third_op  = imm_j;
            end
            default: ;
        endcase
    end

    assign we = (rd != '0) && (op inside {rs5_isa_pkg::ADD, rs5_isa_pkg::SUB,
                                          rs5_isa_pkg::AND, rs5_isa_pkg::OR,
                                          rs5_isa_pkg::XOR, rs5_isa_pkg::LUI,
                                          rs5_isa_pkg::LW, rs5_isa_pkg::JAL});

    // Wait while execute still owns a source register of this instruction
    assign hazard_o = dec_exe_o.valid && dec_exe_o.we && (dec_exe_o.tag == tag_i)
                      && ((use_rs1 && rs1_o == dec_exe_o.rd)
                          || (use_rs2 && rs2_o == dec_exe_o.rd));

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_exe_o.valid <= 1'b0;
            dec_exe_o.op    <= rs5_isa_pkg::NOP;
        end else if (!stall_i) begin
            if (jump_i || hazard_o) begin
                dec_exe_o.valid <= 1'b0;
                dec_exe_o.op    <= rs5_isa_pkg::NOP;
            end else begin
                dec_exe_o <= '{valid: 1'b1, op: op, rd: rd, first_op: first_op,
                               second_op: second_op, third_op: third_op,
                               pc: pc_i, tag: tag_i, we: we};
            end
        end
    end

endmodule

//--- rs5_regbank.sv
// Register bank of thirty-one registers with x0 at zero and write-through on read
`timescale 1ns/1ps

module rs5_regbank (
    input  logic                   clk,
    input  logic                   reset,
    input  rs5_isa_pkg::reg_addr_t rs1_i,
    input  rs5_isa_pkg::reg_addr_t rs2_i,
    input  logic                   we_i,
    input  rs5_isa_pkg::reg_addr_t rd_i,
    input  rs5_isa_pkg::word_t     data_i,
    output rs5_isa_pkg::word_t     data1_o,
    output rs5_isa_pkg::word_t     data2_o
);

    rs5_isa_pkg::word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= data_i;
        end
    end

    // Same-cycle write wins over the stored value
    assign data1_o = (rs1_i == '0) ? '0 : (we_i && rd_i == rs1_i) ? data_i : regs[rs1_i];
    assign data2_o = (rs2_i == '0) ? '0 : (we_i && rd_i == rs2_i) ? data_i : regs[rs2_i];

endmodule

//--- rs5_execute.sv
// Execute stage with ALU, branch compare, address generation and load hold on a pending store
`timescale 1ns/1ps

module rs5_execute (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall_i,
    input  logic                    jump_i,
    input  rs5_pipe_pkg::dec_exe_t  dec_exe_i,
    input  logic                    store_pending_i,
    output rs5_pipe_pkg::exe_ret_t  exe_ret_o,
    output rs5_pipe_pkg::dmem_req_t load_req_o,
    output logic                    conflict_o
);

    rs5_isa_pkg::word_t sum, result;
    logic               taken, is_load;

    always_comb begin
        if (dec_exe_i.op == rs5_isa_pkg::SUB) begin
            sum = dec_exe_i.first_op - dec_exe_i.second_op;
        end else begin
            sum = dec_exe_i.first_op + dec_exe_i.second_op;
        end
        case (dec_exe_i.op)
            rs5_isa_pkg::AND: result = dec_exe_i.first_op & dec_exe_i.second_op;
            rs5_isa_pkg::OR:  result = dec_exe_i.first_op | dec_exe_i.second_op;
            rs5_isa_pkg::XOR: result = dec_exe_i.first_op ^ dec_exe_i.second_op;
            rs5_isa_pkg::LUI: result = dec_exe_i.second_op;
            default:          result = sum;
        endcase
        case (dec_exe_i.op)
            rs5_isa_pkg::BEQ: taken = (dec_exe_i.first_op == dec_exe_i.second_op);
            rs5_isa_pkg::BNE: taken = (dec_exe_i.first_op != dec_exe_i.second_op);
            rs5_isa_pkg::JAL: taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    //////////////////////////////
    // Load port
    //////////////////////////////
    assign is_load    = dec_exe_i.valid && (dec_exe_i.op == rs5_isa_pkg::LW);
    // Retire owns the port while it holds a store
    assign conflict_o = is_load && store_pending_i;

    assign load_req_o.en    = is_load && !store_pending_i && !stall_i;
    assign load_req_o.write = 1'b0;
    assign load_req_o.addr  = {sum[31:2], 2'b00};
    assign load_req_o.wdata = '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_ret_o.valid <= 1'b0;
            exe_ret_o.op    <= rs5_isa_pkg::NOP;
        end else if (!stall_i) begin
            if (jump_i || conflict_o) begin
                exe_ret_o.valid <= 1'b0;
                exe_ret_o.op    <= rs5_isa_pkg::NOP;
            end else begin
                exe_ret_o <= '{valid: dec_exe_i.valid, op: dec_exe_i.op, rd: dec_exe_i.rd,
                               result: result, target: dec_exe_i.pc + dec_exe_i.third_op,
                               store_data: dec_exe_i.third_op, tag: dec_exe_i.tag,
                               we: dec_exe_i.we, jump: taken};
            end
        end
    end

endmodule

//--- rs5_retire.sv
// Retire stage that drops stale-tag work, writes back, issues stores and resolves jumps
`timescale 1ns/1ps

module rs5_retire (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall_i,
    input  rs5_pipe_pkg::exe_ret_t  exe_ret_i,
    input  rs5_isa_pkg::word_t      mem_data_i,
    output logic                    reg_we_o,
    output rs5_isa_pkg::reg_addr_t  reg_rd_o,
    output rs5_isa_pkg::word_t      reg_data_o,
    output rs5_pipe_pkg::dmem_req_t store_req_o,
    output logic                    store_pending_o,
    output logic                    jump_o,
    output rs5_isa_pkg::word_t      jump_target_o
);

    rs5_isa_pkg::tag_t cur_tag;
    logic              live;

    // Anything fetched before the last taken jump carries an older tag
    assign live = exe_ret_i.valid && (exe_ret_i.tag == cur_tag);

    always_ff @(posedge clk) begin
        if (reset) begin
            cur_tag <= '0;
        end else if (!stall_i && jump_o) begin
            cur_tag <= cur_tag + 1'b1;
        end
    end

    assign jump_o        = live && exe_ret_i.jump;
    assign jump_target_o = exe_ret_i.target;

    //////////////////////////////
    // Writeback
    //////////////////////////////
    assign reg_we_o   = live && exe_ret_i.we && !stall_i;
    assign reg_rd_o   = exe_ret_i.rd;
    assign reg_data_o = (exe_ret_i.op == rs5_isa_pkg::LW) ? mem_data_i : exe_ret_i.result;

    //////////////////////////////
    // Store
    //////////////////////////////
    assign store_pending_o   = live && (exe_ret_i.op == rs5_isa_pkg::SW);
    assign store_req_o.en    = store_pending_o && !stall_i;
    assign store_req_o.write = store_pending_o && !stall_i;
    assign store_req_o.addr  = {exe_ret_i.result[31:2], 2'b00};
    assign store_req_o.wdata = exe_ret_i.store_data;

endmodule

//--- rs5_core.sv
// Four-stage RV32I subset core connecting fetch, decode, execute, retire and the register bank
`timescale 1ns/1ps

module rs5_core #(
    parameter rs5_isa_pkg::word_t RESET_ADDR = '0
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall_i,
    input  rs5_isa_pkg::word_t      instruction_i,
    input  rs5_isa_pkg::word_t      mem_data_i,
    output rs5_isa_pkg::word_t      instruction_address_o,
    output rs5_pipe_pkg::dmem_req_t dmem_req_o
);

    logic                    hazard, conflict, fetch_hold, decode_stall;
    logic                    jump, store_pending, reg_we;
    rs5_isa_pkg::word_t      jump_target, pc_dec, rs1_data, rs2_data, reg_data;
    rs5_isa_pkg::tag_t       tag_dec;
    rs5_isa_pkg::reg_addr_t  rs1, rs2, reg_rd;
    rs5_pipe_pkg::dec_exe_t  dec_exe;
    rs5_pipe_pkg::exe_ret_t  exe_ret;
    rs5_pipe_pkg::dmem_req_t load_req, store_req;

    // A load held behind a store freezes the front end for that cycle
    assign fetch_hold   = hazard | conflict;
    assign decode_stall = stall_i | conflict;

    rs5_fetch #(
        .RESET_ADDR(RESET_ADDR)
    ) fetch_i (
        .clk(clk),
        .reset(reset),
        .stall_i(stall_i),
        .hazard_i(fetch_hold),
        .jump_i(jump),
        .jump_target_i(jump_target),
        .instruction_address_o(instruction_address_o),
        .pc_o(pc_dec),
        .tag_o(tag_dec)
    );

    rs5_decode decode_i (
        .clk(clk),
        .reset(reset),
        .stall_i(decode_stall),
        .jump_i(jump),
        .instruction_i(instruction_i),
        .pc_i(pc_dec),
        .tag_i(tag_dec),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .rs1_o(rs1),
        .rs2_o(rs2),
        .dec_exe_o(dec_exe),
        .hazard_o(hazard)
    );

    rs5_regbank regbank_i (
        .clk(clk),
        .reset(reset),
        .rs1_i(rs1),
        .rs2_i(rs2),
        .we_i(reg_we),
        .rd_i(reg_rd),
        .data_i(reg_data),
        .data1_o(rs1_data),
        .data2_o(rs2_data)
    );

    rs5_execute execute_i (
        .clk(clk),
        .reset(reset),
        .stall_i(stall_i),
        .jump_i(jump),
        .dec_exe_i(dec_exe),
        .store_pending_i(store_pending),
        .exe_ret_o(exe_ret),
        .load_req_o(load_req),
        .conflict_o(conflict)
    );

    rs5_retire retire_i (
        .clk(clk),
        .reset(reset),
        .stall_i(stall_i),
        .exe_ret_i(exe_ret),
        .mem_data_i(mem_data_i),
        .reg_we_o(reg_we),
        .reg_rd_o(reg_rd),
        .reg_data_o(reg_data),
        .store_req_o(store_req),
        .store_pending_o(store_pending),
        .jump_o(jump),
        .jump_target_o(jump_target)
    );

    // Single data port, a retiring store has priority over a load
    assign dmem_req_o = store_req.en ? store_req : load_req;

endmodule

//--- rs5_core_tb.sv
// Self-checking testbench for the RV32I subset core with memory models and a store comparator
`timescale 1ns/1ps

module rs5_core_tb;

    localparam int MEM_WORDS      = 256;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int QUIET_CYCLES   = 30;

    logic                    clk;
    logic                    reset;
    logic                    stall_i;
    rs5_isa_pkg::word_t      instruction_i;
    rs5_isa_pkg::word_t      mem_data_i;
    rs5_isa_pkg::word_t      instruction_address_o;
    rs5_pipe_pkg::dmem_req_t dmem_req_o;

    rs5_isa_pkg::word_t imem [MEM_WORDS];
    rs5_isa_pkg::word_t dmem [MEM_WORDS];
    rs5_isa_pkg::word_t exp_addr [$];
    rs5_isa_pkg::word_t exp_data [$];

    integer seed;
    int     prog_len;
    logic   stall_en;
    string  test_name;
    int     test_errors;
    int     errors;
    int     checks;
    int     tests_run;
    int     tests_failed;

    rs5_core #(
        .RESET_ADDR(32'h0)
    ) DUT (
        .clk(clk),
        .reset(reset),
        .stall_i(stall_i),
        .instruction_i(instruction_i),
        .mem_data_i(mem_data_i),
        .instruction_address_o(instruction_address_o),
        .dmem_req_o(dmem_req_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // Memory models
    //////////////////////////////
    // Read data follows one cycle after the address, data output holds when idle
    always @(posedge clk) begin
        instruction_i <= imem[instruction_address_o[9:2]];
        if (dmem_req_o.en && dmem_req_o.write) begin
            dmem[dmem_req_o.addr[9:2]] <= dmem_req_o.wdata;
        end else if (dmem_req_o.en) begin
            mem_data_i <= dmem[dmem_req_o.addr[9:2]];
        end
    end

    // About 30 percent stall cycles when enabled
    always @(posedge clk) begin
        if (stall_en) begin
            stall_i <= (($unsigned($random(seed)) % 100) < 30);
        end else begin
            stall_i <= 1'b0;
        end
    end

    // Store comparator against the head of the expected list
    always @(posedge clk) begin
        if (!reset && dmem_req_o.en && dmem_req_o.write) begin
            checks++;
            assert (exp_addr.size() != 0) else begin
                $display("Test %s: store of %h to %h arrived when no store was expected",
                         test_name, dmem_req_o.wdata, dmem_req_o.addr);
                test_errors++;
            end
            if (exp_addr.size() != 0) begin
                assert (dmem_req_o.addr == exp_addr[0] && dmem_req_o.wdata == exp_data[0])
                else begin
                    $display("Fail %s: expected %h at %h, actual %h at %h", test_name,
                             exp_data[0], exp_addr[0], dmem_req_o.wdata, dmem_req_o.addr);
                    test_errors++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    //////////////////////////////
    // Instruction encoders
    //////////////////////////////
    function automatic rs5_isa_pkg::word_t r_type(input int f7, input int f3, input int rd,
                                                  input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rs5_isa_pkg::OPC_OP};
    endfunction

    function automatic rs5_isa_pkg::word_t i_type(input logic [6:0] opc, input int f3,
                                                  input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic rs5_isa_pkg::word_t s_type(input int rs1, input int rs2, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], rs5_isa_pkg::OPC_STORE};
    endfunction

    function automatic rs5_isa_pkg::word_t b_type(input int f3, input int rs1, input int rs2,
                                                  input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                rs5_isa_pkg::OPC_BRANCH};
    endfunction

    function automatic rs5_isa_pkg::word_t u_type(input int rd, input int imm);
        return {imm[19:0], rd[4:0], rs5_isa_pkg::OPC_LUI};
    endfunction

    function automatic rs5_isa_pkg::word_t j_type(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rs5_isa_pkg::OPC_JAL};
    endfunction

    function automatic rs5_isa_pkg::word_t fill_value(input int index);
        return (index * 32'h9e3779b1) ^ 32'h5a5a_0000 ^ (index << 2);
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////
    // Runs the program from imem until the self-looping JAL, listing every store
    function automatic void run_reference;
        rs5_isa_pkg::word_t regs [32];
        rs5_isa_pkg::word_t mem [MEM_WORDS];
        rs5_isa_pkg::word_t pc, next, ins, a, b, res, addr, imm_i, imm_s, imm_b, imm_j;
        logic               wr;
        logic               done;
        int                 steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_value(i);
        end
        pc    = 32'h0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 4000) begin
            ins   = imem[pc[9:2]];
            a     = regs[ins[19:15]];
            b     = regs[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            wr    = 1'b1;
            res   = '0;
            next  = pc + 32'd4;
            case (ins[6:0])
                rs5_isa_pkg::OPC_OP: begin
                    case ({ins[30], ins[14:12]})
                        4'b0000: res = a + b;
                        4'b1000: res = a - b;
                        4'b0111: res = a & b;
                        4'b0110: res = a | b;
                        default: res = a ^ b;
                    endcase
                end
                rs5_isa_pkg::OPC_OP_IMM: res = a + imm_i;
                rs5_isa_pkg::OPC_LUI:    res = {ins[31:12], 12'b0};
                rs5_isa_pkg::OPC_LOAD: begin
                    addr = a + imm_i;
                    res  = mem[addr[9:2]];
                end
                rs5_isa_pkg::OPC_STORE: begin
                    addr           = a + imm_s;
                    wr             = 1'b0;
                    mem[addr[9:2]] = b;
                    exp_addr.push_back({addr[31:2], 2'b00});
                    exp_data.push_back(b);
                end
                rs5_isa_pkg::OPC_BRANCH: begin
                    wr = 1'b0;
                    if ((ins[14:12] == 3'b000) ? (a == b) : (a != b)) begin
                        next = pc + imm_b;
                    end
                end
                rs5_isa_pkg::OPC_JAL: begin
                    res  = pc + 32'd4;
                    next = pc + imm_j;
                    done = (imm_j == '0);
                end
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                regs[ins[11:7]] = res;
            end
            pc = next;
            steps++;
        end
    endfunction

    //////////////////////////////
    // Test sequencing
    //////////////////////////////
    task automatic put_word(input rs5_isa_pkg::word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // Core is held in reset while the memories get their new contents
    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);
        exp_addr.delete();
        exp_data.delete();
        prog_len = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = fill_value(i);
        end
    endtask

    task automatic release_reset;
        @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_for_stores;
        int cycles;
        cycles = 0;
        while (exp_addr.size() != 0 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_addr.size() != 0) begin
            $display("Test %s: timed out, %0d expected stores never arrived",
                     test_name, exp_addr.size());
            test_errors++;
            exp_addr.delete();
            exp_data.delete();
        end
        // Quiet period catches stores from killed or repeated instructions
        cycles = 0;
        while (cycles < QUIET_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic finish_test;
        stall_en = 1'b0;
        tests_run++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("Test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", test_name, test_errors);
        end
    endtask

    // Random ALU chain, then every used register stored to 0x100 + 4 * index
    task automatic build_random_program;
        int kind;
        int rd;
        int rs1;
        int rs2;
        int last_rd;
        seed    = 32'h522f;
        last_rd = 0;
        for (int n = 0; n < 40; n++) begin
            kind = $unsigned($random(seed)) % 7;
            rd   = 1 + $unsigned($random(seed)) % 15;
            rs1  = ($random(seed) & 1) ? last_rd : $unsigned($random(seed)) % 16;
            rs2  = ($random(seed) & 1) ? last_rd : $unsigned($random(seed)) % 16;
            case (kind)
                0: put_word(r_type(0, 0, rd, rs1, rs2));
                1: put_word(r_type(32, 0, rd, rs1, rs2));
                2: put_word(r_type(0, 7, rd, rs1, rs2));
                3: put_word(r_type(0, 6, rd, rs1, rs2));
                4: put_word(r_type(0, 4, rd, rs1, rs2));
                5: put_word(i_type(rs5_isa_pkg::OPC_OP_IMM, 0, rd, rs1, $random(seed)));
                default: put_word(u_type(rd, $random(seed)));
            endcase
            last_rd = rd;
        end
        for (int r = 1; r < 16; r++) begin
            put_word(s_type(0, r, 256 + 4 * r));
        end
        put_word(j_type(0, 0));
    endtask

    initial begin
        reset         = 1'b1;
        stall_i       = 1'b0;
        instruction_i = '0;
        mem_data_i    = '0;
        stall_en      = 1'b0;
        seed          = 32'h522f;
        test_errors   = 0;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        tests_failed  = 0;

        start_test("reset");
        put_word(j_type(0, 0));
        release_reset();
        @(negedge clk);
        checks += 2;
        assert (instruction_address_o == 32'h0) else begin
            $display("Fail reset: expected %h, actual %h", 32'h0, instruction_address_o);
            test_errors++;
        end
        assert (dmem_req_o.en == 1'b0) else begin
            $display("Fail reset: expected %b, actual %b", 1'b0, dmem_req_o.en);
            test_errors++;
        end
        wait_for_stores();
        finish_test();

        start_test("alu_chain");
        build_random_program();
        run_reference();
        release_reset();
        wait_for_stores();
        finish_test();

        start_test("load_store");
        put_word(i_type(rs5_isa_pkg::OPC_OP_IMM, 0, 1, 0, 'h123));
        put_word(u_type(2, 'habcde));
        put_word(i_type(rs5_isa_pkg::OPC_OP_IMM, 0, 2, 2, 'h456));
        put_word(i_type(rs5_isa_pkg::OPC_OP_IMM, 0, 3, 0, 'h200));
        put_word(s_type(3, 2, 0));
        // Load right behind the store, then a load-use add
        put_word(i_type(rs5_isa_pkg::OPC_LOAD, 2, 4, 3, 0));
        put_word(r_type(0, 0, 5, 4, 1));
        put_word(s_type(3, 5, 4));
        put_word(i_type(rs5_isa_pkg::OPC_LOAD, 2, 6, 3, 'h00c));
        put_word(s_type(3, 6, 8));
        put_word(j_type(0, 0));
        run_reference();
        release_reset();
        wait_for_stores();
        finish_test();

        start_test("branch_jump");
        put_word(i_type(rs5_isa_pkg::OPC_OP_IMM, 0, 1, 0, 5));
        put_word(i_type(rs5_isa_pkg::OPC_OP_IMM, 0, 2, 0, 5));
        put_word(i_type(rs5_isa_pkg::OPC_OP_IMM, 0, 3, 0, 7));
        put_word(b_type(0, 1, 2, 8));
        put_word(s_type(0, 1, 'h300));
        put_word(b_type(1, 1, 2, 8));
        put_word(s_type(0, 2, 'h304));
        put_word(b_type(1, 1, 3, 12));
        put_word(s_type(0, 3, 'h308));
        put_word(s_type(0, 3, 'h30c));
        put_word(b_type(0, 1, 3, 8));
        put_word(s_type(0, 3, 'h310));
        put_word(j_type(5, 12));
        put_word(s_type(0, 1, 'h314));
        put_word(s_type(0, 1, 'h318));
        put_word(s_type(0, 5, 'h31c));
        // Countdown loop with a backward BNE
        put_word(i_type(rs5_isa_pkg::OPC_OP_IMM, 0, 6, 0, 3));
        put_word(i_type(rs5_isa_pkg::OPC_OP_IMM, 0, 6, 6, -1));
        put_word(s_type(0, 6, 'h320));
        put_word(b_type(1, 6, 0, -8));
        put_word(j_type(0, 0));
        run_reference();
        release_reset();
        wait_for_stores();
        finish_test();

        start_test("alu_chain_stall");
        build_random_program();
        run_reference();
        release_reset();
        stall_en = 1'b1;
        wait_for_stores();
        finish_test();

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- rs5_core.f
rs5_isa_pkg.sv
rs5_pipe_pkg.sv
rs5_fetch.sv
rs5_decode.sv
rs5_regbank.sv
rs5_execute.sv
rs5_retire.sv
rs5_core.sv
rs5_core_tb.sv
